// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_gpu_core
FILELIST  = list.f
LOG       = sim.log

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: buffer_clear.sv
// fills SCREEN_PIXELS consecutive words from base; base and fill are sampled on go only
`timescale 1ns/1ps

module buffer_clear (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   go,
    input  gpu_mem_pkg::mem_addr_t base,
    input  gpu_mem_pkg::mem_data_t fill,
    output logic                   done,
    mem_port_if.requester          mem
);
    import gpu_mem_pkg::*;

    localparam int CNT_W = $clog2(SCREEN_PIXELS);

    logic             busy;
    logic [CNT_W-1:0] count;
    mem_addr_t        addr;
    mem_data_t        data;

    // one write per cycle while busy
    assign mem.req       = busy;
    assign mem.write     = busy;
    assign mem.read      = 1'b0;
    assign mem.address   = addr;
    assign mem.writedata = data;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy && go) begin
                busy <= 1'b1;
            end else if (busy && !mem.waitrequest && count == CNT_W'(SCREEN_PIXELS - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // address and count step only on an accepted write
    always_ff @(posedge CLK) begin
        if (!busy && go) begin
            addr  <= base;
            data  <= fill;
            count <= '0;
        end else if (busy && !mem.waitrequest) begin
            addr  <= addr + mem_addr_t'(BYTES_PER_PIXEL);
            count <= count + 1'b1;
        end
    end

endmodule

// File: gpu_control.sv
// host register file and job sequencer; a new job needs start cleared and written again
`timescale 1ns/1ps

module gpu_control (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     GPU_SLAVE_read,
    input  logic                     GPU_SLAVE_write,
    input  logic                     GPU_SLAVE_chipselect,
    input  gpu_regs_pkg::reg_addr_e  GPU_SLAVE_address,
    input  gpu_mem_pkg::mem_data_t   GPU_SLAVE_writedata,
    output gpu_mem_pkg::mem_data_t   GPU_SLAVE_readdata,
    input  logic                     clear_done,
    input  logic                     plot_done,
    output logic                     clear_go,
    output logic                     plot_go,
    output gpu_mem_pkg::mem_addr_t   clear_base,
    output gpu_mem_pkg::mem_data_t   clear_fill,
    output gpu_regs_pkg::pixel_cmd_t pixel,
    output gpu_mem_pkg::mem_addr_t   frame_ptr,
    output gpu_mem_pkg::mem_addr_t   depth_ptr
);
    import gpu_mem_pkg::*;
    import gpu_regs_pkg::*;

    typedef enum logic [1:0] {JOB_IDLE, JOB_RUNNING, JOB_DONE} job_state_e;

    job_state_e job_state;
    logic       start;
    logic       done;
    mem_data_t  mode;
    logic       skip_job;
    logic       job_end;

    // depth clear goes to the depth buffer, all else to the frame
    assign clear_base = (mode == MODE_CLEAR_DEPTH) ? depth_ptr : frame_ptr;
    assign clear_fill = (mode == MODE_CLEAR_DEPTH) ? DEPTH_FILL : FRAME_FILL;

    assign job_end = (job_state == JOB_RUNNING) && (clear_done || plot_done || skip_job);

    // slave read mux
    always_comb begin
        GPU_SLAVE_readdata = '0;
        if (GPU_SLAVE_chipselect && GPU_SLAVE_read) begin
            case (GPU_SLAVE_address)
                FRAME_PTR: GPU_SLAVE_readdata = frame_ptr;
                START:     GPU_SLAVE_readdata = {31'b0, start};
                DONE:      GPU_SLAVE_readdata = {31'b0, done};
                DEPTH_PTR: GPU_SLAVE_readdata = depth_ptr;
                POS_X:     GPU_SLAVE_readdata = pixel.x;
                POS_Y:     GPU_SLAVE_readdata = pixel.y;
                POS_Z:     GPU_SLAVE_readdata = pixel.z;
                MODE:      GPU_SLAVE_readdata = mode;
                COLOR:     GPU_SLAVE_readdata = {8'h00, pixel.color};
                default:   GPU_SLAVE_readdata = '0;
            endcase
        end
    end

    // slave writes, then done set by the sequencer
    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_ptr <= '0;
            depth_ptr <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
            mode      <= '0;
            pixel     <= '0;
        end else begin
            if (GPU_SLAVE_chipselect && GPU_SLAVE_write) begin
                case (GPU_SLAVE_address)
                    FRAME_PTR: frame_ptr   <= GPU_SLAVE_writedata;
                    START:     start       <= GPU_SLAVE_writedata[0];
                    DONE:      done        <= GPU_SLAVE_writedata[0];
                    DEPTH_PTR: depth_ptr   <= GPU_SLAVE_writedata;
                    POS_X:     pixel.x     <= GPU_SLAVE_writedata;
                    POS_Y:     pixel.y     <= GPU_SLAVE_writedata;
                    POS_Z:     pixel.z     <= GPU_SLAVE_writedata;
                    MODE:      mode        <= GPU_SLAVE_writedata;
                    COLOR:     pixel.color <= GPU_SLAVE_writedata[23:0];
                    default:   ;
                endcase
            end
            if (job_end) begin
                done <= 1'b1;
            end
        end
    end

    // job sequencer, go pulses land in the first RUNNING cycle
    always_ff @(posedge CLK) begin
        if (RESET) begin
            job_state <= JOB_IDLE;
            clear_go  <= 1'b0;
            plot_go   <= 1'b0;
            skip_job  <= 1'b0;
        end else begin
            clear_go <= 1'b0;
            plot_go  <= 1'b0;
            skip_job <= 1'b0;
            case (job_state)
                JOB_IDLE: begin
                    if (start) begin
                        job_state <= JOB_RUNNING;
                        case (mode)
                            MODE_PLOT:                          plot_go  <= 1'b1;
                            MODE_CLEAR_FRAME, MODE_CLEAR_DEPTH: clear_go <= 1'b1;
                            default:                            skip_job <= 1'b1;
                        endcase
                    end
                end
                JOB_RUNNING: begin
                    if (job_end) begin
                        job_state <= JOB_DONE;
                    end
                end
                JOB_DONE: begin
                    // wait for the host to drop start
                    if (!start) begin
                        job_state <= JOB_IDLE;
                    end
                end
                default: job_state <= JOB_IDLE;
            endcase
        end
    end

endmodule

// File: gpu_core.sv
// top level with Avalon-style slave and master ports; one master transaction at a time
`timescale 1ns/1ps

module gpu_core (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    GPU_SLAVE_read,
    input  logic                    GPU_SLAVE_write,
    input  logic                    GPU_SLAVE_chipselect,
    input  gpu_regs_pkg::reg_addr_e GPU_SLAVE_address,
    input  gpu_mem_pkg::mem_data_t  GPU_SLAVE_writedata,
    output gpu_mem_pkg::mem_data_t  GPU_SLAVE_readdata,
    output gpu_mem_pkg::mem_addr_t  GPU_MASTER_address,
    output logic                    GPU_MASTER_read,
    output logic                    GPU_MASTER_write,
    output logic                    GPU_MASTER_chipselect,
    output gpu_mem_pkg::mem_data_t  GPU_MASTER_writedata,
    input  gpu_mem_pkg::mem_data_t  GPU_MASTER_readdata,
    input  logic                    GPU_MASTER_readdatavalid,
    input  logic                    GPU_MASTER_waitrequest
);
    import gpu_mem_pkg::*;
    import gpu_regs_pkg::*;

    logic       clear_go;
    logic       plot_go;
    logic       clear_done;
    logic       plot_done;
    mem_addr_t  clear_base;
    mem_data_t  clear_fill;
    pixel_cmd_t pixel;
    mem_addr_t  frame_ptr;
    mem_addr_t  depth_ptr;

    // clear engine on port a, plot engine on port b
    mem_port_if clear_bus ();
    mem_port_if plot_bus ();

    gpu_control u_control (
        .CLK, .RESET,
        .GPU_SLAVE_read, .GPU_SLAVE_write, .GPU_SLAVE_chipselect,
        .GPU_SLAVE_address, .GPU_SLAVE_writedata, .GPU_SLAVE_readdata,
        .clear_done, .plot_done, .clear_go, .plot_go,
        .clear_base, .clear_fill, .pixel, .frame_ptr, .depth_ptr
    );

    buffer_clear u_clear (
        .CLK, .RESET, .go(clear_go), .base(clear_base), .fill(clear_fill),
        .done(clear_done), .mem(clear_bus.requester)
    );

    pixel_plot u_plot (
        .CLK, .RESET, .go(plot_go), .pixel, .frame_ptr, .depth_ptr,
        .done(plot_done), .mem(plot_bus.requester)
    );

    mem_arbiter u_arbiter (
        .CLK, .RESET,
        .GPU_MASTER_address, .GPU_MASTER_read, .GPU_MASTER_write,
        .GPU_MASTER_chipselect, .GPU_MASTER_writedata, .GPU_MASTER_readdata,
        .GPU_MASTER_readdatavalid, .GPU_MASTER_waitrequest,
        .req_a(clear_bus.arbiter), .req_b(plot_bus.arbiter)
    );

endmodule

// File: gpu_core_props.sv
// bus and job checks for the GPU core; bound twice, unused inputs of each binding tied low
`timescale 1ns/1ps

module gpu_core_props (
    input logic                   CLK,
    input logic                   RESET,
    input logic                   rd,
    input logic                   wr,
    input gpu_mem_pkg::mem_addr_t addr,
    input logic                   wait_req,
    input logic                   done_flag,
    input logic                   done_set,
    input logic                   done_wr
);

    // a master transfer is either a read or a write
    assert property (@(posedge CLK) disable iff (RESET) !(rd && wr))
        else $error("master read and write high together");

    // a stalled transfer keeps its request and address
    assert property (@(posedge CLK) disable iff (RESET)
        (rd || wr) && wait_req |=> (rd || wr) && $stable(addr))
        else $error("master address changed under waitrequest");

    // done only comes from a finished job or a host write of 1
    assert property (@(posedge CLK) disable iff (RESET)
        $rose(done_flag) |-> $past(done_set || done_wr))
        else $error("done rose without a job");

endmodule

bind mem_arbiter gpu_core_props u_bus_props (
    .CLK, .RESET,
    .rd(GPU_MASTER_read), .wr(GPU_MASTER_write), .addr(GPU_MASTER_address),
    .wait_req(GPU_MASTER_waitrequest),
    .done_flag(1'b0), .done_set(1'b0), .done_wr(1'b0)
);

bind gpu_control gpu_core_props u_job_props (
    .CLK, .RESET,
    .rd(1'b0), .wr(1'b0), .addr(32'h0), .wait_req(1'b0),
    .done_flag(done), .done_set(job_end),
    .done_wr(GPU_SLAVE_chipselect && GPU_SLAVE_write
             && GPU_SLAVE_address == gpu_regs_pkg::DONE && GPU_SLAVE_writedata[0])
);

// File: gpu_mem_pkg.sv
// fixed 320x240 buffers of 32-bit words, one word per pixel, coordinates and depth in 24.8 signed
package gpu_mem_pkg;

    // screen geometry
    localparam int SCREEN_W = 320;
    localparam int SCREEN_H = 240;
    localparam int SCREEN_PIXELS = SCREEN_W * SCREEN_H;

    // fractional bits of x, y and z
    localparam int FRAC_BITS = 8;

    // byte stride between neighbouring pixels
    localparam int BYTES_PER_PIXEL = 4;

    typedef logic [31:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // sky blue background
    localparam mem_data_t FRAME_FILL = 32'h0087_CEEB;

    // farthest depth, largest positive value
    localparam mem_data_t DEPTH_FILL = 32'h7FFF_FFFF;

    // pure yellow is never drawn
    localparam rgb_t COLOR_KEY = '{r: 8'hFF, g: 8'hFF, b: 8'h00};

endpackage

// File: gpu_regs_pkg.sv
// register map of the slave port; addresses are word indices, unlisted ones read as zero
package gpu_regs_pkg;

    // slave register addresses
    typedef enum logic [31:0] {
        FRAME_PTR = 32'd0,
        START     = 32'd1,
        DONE      = 32'd2,
        DEPTH_PTR = 32'd3,
        POS_X     = 32'd5,
        POS_Y     = 32'd6,
        POS_Z     = 32'd7,
        MODE      = 32'd8,
        COLOR     = 32'd10
    } reg_addr_e;

    // job selected by the mode register
    typedef enum logic [31:0] {
        MODE_PLOT        = 32'd1,
        MODE_CLEAR_FRAME = 32'd2,
        MODE_CLEAR_DEPTH = 32'd3
    } job_mode_e;

    // one pixel as the host wrote it
    typedef struct packed {
        logic signed [31:0]  x;
        logic signed [31:0]  y;
        logic signed [31:0]  z;
        gpu_mem_pkg::rgb_t   color;
    } pixel_cmd_t;

endpackage

// File: list.f
gpu_mem_pkg.sv
gpu_regs_pkg.sv
mem_port_if.sv
gpu_control.sv
buffer_clear.sv
pixel_plot.sv
mem_arbiter.sv
gpu_core.sv
gpu_core_props.sv
tb_gpu_core.sv

// File: mem_arbiter.sv
// two-way round robin; the owner keeps the bus until it drops req, so never mid-transfer
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                   CLK,
    input  logic                   RESET,
    output gpu_mem_pkg::mem_addr_t GPU_MASTER_address,
    output logic                   GPU_MASTER_read,
    output logic                   GPU_MASTER_write,
    output logic                   GPU_MASTER_chipselect,
    output gpu_mem_pkg::mem_data_t GPU_MASTER_writedata,
    input  gpu_mem_pkg::mem_data_t GPU_MASTER_readdata,
    input  logic                   GPU_MASTER_readdatavalid,
    input  logic                   GPU_MASTER_waitrequest,
    mem_port_if.arbiter            req_a,
    mem_port_if.arbiter            req_b
);
    logic owner_b;
    logic owner_req;
    logic other_req;

    assign owner_req = owner_b ? req_b.req : req_a.req;
    assign other_req = owner_b ? req_a.req : req_b.req;

    // hand over only when the owner is idle and the other one waits
    always_ff @(posedge CLK) begin
        if (RESET) begin
            owner_b <= 1'b0;
        end else if (!owner_req && other_req) begin
            owner_b <= !owner_b;
        end
    end

    assign GPU_MASTER_address    = owner_b ? req_b.address : req_a.address;
    assign GPU_MASTER_writedata  = owner_b ? req_b.writedata : req_a.writedata;
    assign GPU_MASTER_read       = owner_b ? req_b.read : req_a.read;
    assign GPU_MASTER_write      = owner_b ? req_b.write : req_a.write;
    assign GPU_MASTER_chipselect = GPU_MASTER_read || GPU_MASTER_write;

    // the side without the bus is stalled and sees no read data
    assign req_a.waitrequest   = owner_b || GPU_MASTER_waitrequest;
    assign req_b.waitrequest   = !owner_b || GPU_MASTER_waitrequest;
    assign req_a.readdatavalid = !owner_b && GPU_MASTER_readdatavalid;
    assign req_b.readdatavalid = owner_b && GPU_MASTER_readdatavalid;
    assign req_a.readdata      = owner_b ? '0 : GPU_MASTER_readdata;
    assign req_b.readdata      = owner_b ? GPU_MASTER_readdata : '0;

endmodule

// File: mem_port_if.sv
// one requester on the shared memory bus; req must stay high across a whole transaction
`timescale 1ns/1ps

interface mem_port_if;
    import gpu_mem_pkg::*;

    // requester side
    logic      req;
    logic      read;
    logic      write;
    mem_addr_t address;
    mem_data_t writedata;

    // arbiter side
    logic      waitrequest;
    mem_data_t readdata;
    logic      readdatavalid;

    modport requester (
        output req, read, write, address, writedata,
        input  waitrequest, readdata, readdatavalid
    );

    modport arbiter (
        input  req, read, write, address, writedata,
        output waitrequest, readdata, readdatavalid
    );

endinterface

// File: pixel_plot.sv
// plots one pixel with depth test; x and y use the integer part, the pixel is sampled on go
`timescale 1ns/1ps

module pixel_plot (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     go,
    input  gpu_regs_pkg::pixel_cmd_t pixel,
    input  gpu_mem_pkg::mem_addr_t   frame_ptr,
    input  gpu_mem_pkg::mem_addr_t   depth_ptr,
    output logic                     done,
    mem_port_if.requester            mem
);
    import gpu_mem_pkg::*;

    typedef enum logic [2:0] {P_IDLE, P_READ, P_WAIT, P_COLOR, P_DEPTH} plot_state_e;

    plot_state_e        state;
    logic signed [31:0] x_int;
    logic signed [31:0] y_int;
    mem_addr_t          byte_off;
    logic               on_screen;
    logic               keyed;
    mem_addr_t          color_addr;
    mem_addr_t          depth_addr;
    mem_data_t          color_word;
    mem_data_t          depth_word;

    assign x_int    = pixel.x >>> FRAC_BITS;
    assign y_int    = pixel.y >>> FRAC_BITS;
    assign byte_off = mem_addr_t'((y_int * SCREEN_W + x_int) * BYTES_PER_PIXEL);

    // strict bounds, zero is off screen as well
    assign on_screen = (pixel.x > 0) && (pixel.x < SCREEN_W * (2 ** FRAC_BITS))
                    && (pixel.y > 0) && (pixel.y < SCREEN_H * (2 ** FRAC_BITS));
    assign keyed     = (pixel.color == COLOR_KEY);

    assign mem.req       = (state != P_IDLE);
    assign mem.read      = (state == P_READ);
    assign mem.write     = (state == P_COLOR) || (state == P_DEPTH);
    assign mem.address   = (state == P_COLOR) ? color_addr : depth_addr;
    assign mem.writedata = (state == P_COLOR) ? color_word : depth_word;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= P_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (go) begin
                        if (on_screen && !keyed) begin
                            state <= P_READ;
                        end else begin
                            done <= 1'b1;
                        end
                    end
                end
                P_READ: begin
                    if (!mem.waitrequest) begin
                        state <= P_WAIT;
                    end
                end
                P_WAIT: begin
                    // stored depth must be farther than the new one
                    if (mem.readdatavalid) begin
                        if ($signed(mem.readdata) > $signed(depth_word)) begin
                            state <= P_COLOR;
                        end else begin
                            state <= P_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                P_COLOR: begin
                    if (!mem.waitrequest) begin
                        state <= P_DEPTH;
                    end
                end
                P_DEPTH: begin
                    if (!mem.waitrequest) begin
                        state <= P_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // addresses and words held for the whole job
    always_ff @(posedge CLK) begin
        if (state == P_IDLE && go) begin
            color_addr <= frame_ptr + byte_off;
            depth_addr <= depth_ptr + byte_off;
            color_word <= {8'h00, pixel.color};
            depth_word <= pixel.z;
        end
    end

endmodule

// File: tb_gpu_core.sv
// testbench for gpu_core; memory model stalls at most 3 cycles in a row, read latency 1 to 4
`timescale 1ns/1ps

module tb_gpu_core;
    import gpu_mem_pkg::*;
    import gpu_regs_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int STALL_MAX = 4;
    localparam int PLOT_TESTS = 24;
    localparam longint LIMIT_CYCLES = 2 * SCREEN_PIXELS * STALL_MAX + PLOT_TESTS * 400 + 20000;
    localparam mem_addr_t FRAME_BASE = 32'h0010_0000;
    localparam mem_addr_t DEPTH_BASE = 32'h0020_0000;

    logic      CLK;
    logic      RESET;
    logic      GPU_SLAVE_read;
    logic      GPU_SLAVE_write;
    logic      GPU_SLAVE_chipselect;
    reg_addr_e GPU_SLAVE_address;
    mem_data_t GPU_SLAVE_writedata;
    mem_data_t GPU_SLAVE_readdata;
    mem_addr_t GPU_MASTER_address;
    logic      GPU_MASTER_read;
    logic      GPU_MASTER_write;
    logic      GPU_MASTER_chipselect;
    mem_data_t GPU_MASTER_writedata;
    mem_data_t GPU_MASTER_readdata;
    logic      GPU_MASTER_readdatavalid;
    logic      GPU_MASTER_waitrequest;

    integer    seed = 21;
    int        errors = 0;
    int        checks = 0;
    int        tests_ok = 0;
    int        tests_bad = 0;
    int        test_err_start = 0;
    int        write_count = 0;
    int        wait_run = 0;
    logic      rd_pending = 1'b0;
    int        rd_delay = 0;
    mem_addr_t rd_addr;
    logic      cmp_req = 1'b0;
    mem_data_t mem_model [mem_addr_t];
    mem_addr_t exp_addr_q[$];
    mem_data_t exp_data_q[$];

    gpu_core UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // words never written hold an address-based pattern
    function automatic mem_data_t fill_pattern(mem_addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5A5A_3C3C;
    endfunction

    function automatic mem_data_t mem_read(mem_addr_t a);
        return mem_model.exists(a) ? mem_model[a] : fill_pattern(a);
    endfunction

    // accept transfers on the rising edge
    always @(posedge CLK) begin
        if (!RESET && GPU_MASTER_chipselect && !GPU_MASTER_waitrequest) begin
            if (GPU_MASTER_write) begin
                mem_model[GPU_MASTER_address] = GPU_MASTER_writedata;
                write_count++;
            end
            if (GPU_MASTER_read) begin
                rd_pending = 1'b1;
                rd_delay = 1 + ($unsigned($random(seed)) % 4);
                rd_addr = GPU_MASTER_address;
            end
        end
    end

    // stalls and read data change on the falling edge
    always @(negedge CLK) begin
        if (wait_run >= STALL_MAX - 1) begin
            GPU_MASTER_waitrequest <= 1'b0;
            wait_run = 0;
        end else if (($random(seed) & 3) == 0) begin
            GPU_MASTER_waitrequest <= 1'b1;
            wait_run++;
        end else begin
            GPU_MASTER_waitrequest <= 1'b0;
            wait_run = 0;
        end
        GPU_MASTER_readdatavalid <= 1'b0;
        if (rd_pending) begin
            if (rd_delay <= 1) begin
                GPU_MASTER_readdatavalid <= 1'b1;
                GPU_MASTER_readdata <= mem_read(rd_addr);
                rd_pending = 1'b0;
            end else begin
                rd_delay--;
            end
        end
    end

    task automatic check_word(mem_data_t got, mem_data_t exp, mem_addr_t where);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: word %h is %h, expected %h", $time, where, got, exp);
        end
    endtask

    task automatic slave_write(reg_addr_e a, mem_data_t d);
        @(negedge CLK);
        GPU_SLAVE_chipselect = 1'b1;
        GPU_SLAVE_write = 1'b1;
        GPU_SLAVE_address = a;
        GPU_SLAVE_writedata = d;
        @(negedge CLK);
        GPU_SLAVE_chipselect = 1'b0;
        GPU_SLAVE_write = 1'b0;
    endtask

    task automatic slave_read(reg_addr_e a, output mem_data_t d);
        @(negedge CLK);
        GPU_SLAVE_chipselect = 1'b1;
        GPU_SLAVE_read = 1'b1;
        GPU_SLAVE_address = a;
        #(CLK_PERIOD / 4);
        d = GPU_SLAVE_readdata;
        @(negedge CLK);
        GPU_SLAVE_chipselect = 1'b0;
        GPU_SLAVE_read = 1'b0;
    endtask

    task automatic check_reg(reg_addr_e a, mem_data_t exp);
        mem_data_t got;
        slave_read(a, got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: register %s reads %h, expected %h",
                     $time, a.name(), got, exp);
        end
    endtask

    // job runs until the done register reads 1
    task automatic run_job(mem_data_t mode);
        mem_data_t v;
        slave_write(MODE, mode);
        slave_write(START, 32'd1);
        do begin
            slave_read(DONE, v);
        end while (v[0] !== 1'b1);
        check_reg(DONE, 32'd1);
        slave_write(START, 32'd0);
        slave_write(DONE, 32'd0);
    endtask

    task automatic expect_word(mem_addr_t a, mem_data_t d);
        exp_addr_q.push_back(a);
        exp_data_q.push_back(d);
    endtask

    task automatic compare_now();
        cmp_req = 1'b1;
        wait (cmp_req == 1'b0);
    endtask

    // compare process, drains the expectation queue against the memory model
    initial begin
        mem_addr_t a;
        mem_data_t d;
        forever begin
            wait (cmp_req == 1'b1);
            while (exp_addr_q.size() > 0) begin
                a = exp_addr_q.pop_front();
                d = exp_data_q.pop_front();
                check_word(mem_read(a), d, a);
            end
            cmp_req = 1'b0;
        end
    end

    function automatic mem_addr_t pixel_offset(pixel_cmd_t p);
        int xi;
        int yi;
        xi = p.x >>> FRAC_BITS;
        yi = p.y >>> FRAC_BITS;
        return mem_addr_t'((yi * SCREEN_W + xi) * BYTES_PER_PIXEL);
    endfunction

    // reference: {frame word, depth word} after plotting p over the old words
    function automatic logic [63:0] predict_pixel(pixel_cmd_t p, mem_data_t old_c,
                                                  mem_data_t old_d);
        int  x;
        int  y;
        int  z;
        logic visible;
        x = p.x;
        y = p.y;
        z = p.z;
        visible = (x > 0) && (x < SCREEN_W * 256) && (y > 0) && (y < SCREEN_H * 256);
        if (visible && p.color != COLOR_KEY && $signed(old_d) > z) begin
            return {8'h00, p.color, mem_data_t'(z)};
        end
        return {old_c, old_d};
    endfunction

    task automatic plot_and_check(pixel_cmd_t p);
        mem_addr_t   off;
        logic [63:0] exp;
        off = pixel_offset(p);
        exp = predict_pixel(p, mem_read(FRAME_BASE + off), mem_read(DEPTH_BASE + off));
        slave_write(POS_X, p.x);
        slave_write(POS_Y, p.y);
        slave_write(POS_Z, p.z);
        slave_write(COLOR, {8'h00, p.color});
        run_job(mem_data_t'(MODE_PLOT));
        expect_word(FRAME_BASE + off, exp[63:32]);
        expect_word(DEPTH_BASE + off, exp[31:0]);
        compare_now();
    endtask

    task automatic clear_and_check(mem_data_t mode, mem_addr_t base, mem_data_t fill);
        mem_addr_t past;
        run_job(mode);
        for (int i = 0; i < SCREEN_PIXELS; i++) begin
            expect_word(base + mem_addr_t'(i * BYTES_PER_PIXEL), fill);
        end
        past = base + mem_addr_t'(SCREEN_PIXELS * BYTES_PER_PIXEL);
        expect_word(past, fill_pattern(past));
        compare_now();
    endtask

    task automatic end_test(string name);
        if (errors == test_err_start) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish in %0d cycles", LIMIT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        pixel_cmd_t p;
        pixel_cmd_t q;
        int         writes_before;
        RESET = 1'b1;
        GPU_SLAVE_read = 1'b0;
        GPU_SLAVE_write = 1'b0;
        GPU_SLAVE_chipselect = 1'b0;
        GPU_SLAVE_address = FRAME_PTR;
        GPU_SLAVE_writedata = '0;
        GPU_MASTER_readdata = '0;
        GPU_MASTER_readdatavalid = 1'b0;
        GPU_MASTER_waitrequest = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // reset values, then readback
        check_reg(FRAME_PTR, '0);
        check_reg(START, '0);
        check_reg(DONE, '0);
        check_reg(DEPTH_PTR, '0);
        check_reg(POS_X, '0);
        check_reg(POS_Y, '0);
        check_reg(POS_Z, '0);
        check_reg(MODE, '0);
        check_reg(COLOR, '0);
        slave_write(FRAME_PTR, 32'h1234_5678);
        slave_write(DEPTH_PTR, 32'h0BAD_F00D);
        slave_write(POS_X, 32'hFFFF_FF00);
        slave_write(POS_Y, 32'h0000_1234);
        slave_write(POS_Z, 32'h7654_3210);
        slave_write(MODE, 32'd9);
        slave_write(COLOR, 32'hAB12_3456);
        slave_write(DONE, 32'd1);
        check_reg(FRAME_PTR, 32'h1234_5678);
        check_reg(DEPTH_PTR, 32'h0BAD_F00D);
        check_reg(POS_X, 32'hFFFF_FF00);
        check_reg(POS_Y, 32'h0000_1234);
        check_reg(POS_Z, 32'h7654_3210);
        check_reg(MODE, 32'd9);
        check_reg(COLOR, 32'h0012_3456);
        check_reg(DONE, 32'd1);
        slave_write(DONE, 32'd0);
        end_test("register readback");

        slave_write(FRAME_PTR, FRAME_BASE);
        slave_write(DEPTH_PTR, DEPTH_BASE);
        clear_and_check(mem_data_t'(MODE_CLEAR_FRAME), FRAME_BASE, FRAME_FILL);
        end_test("frame clear");
        clear_and_check(mem_data_t'(MODE_CLEAR_DEPTH), DEPTH_BASE, DEPTH_FILL);
        end_test("depth clear");

        // each new pixel followed by a nearer and a farther one at the same spot
        for (int i = 0; i < PLOT_TESTS / 3; i++) begin
            p.x = 32'((1 + $unsigned($random(seed)) % (SCREEN_W - 1)) * 256
                      + ($random(seed) & 255));
            p.y = 32'((1 + $unsigned($random(seed)) % (SCREEN_H - 1)) * 256
                      + ($random(seed) & 255));
            p.z = 32'(4096 + $unsigned($random(seed)) % 32'h00FF_0000);
            p.color = rgb_t'($random(seed));
            if (p.color == COLOR_KEY) begin
                p.color.b = 8'h01;
            end
            plot_and_check(p);
            q = p;
            q.z = p.z - 1000;
            q.color = ~p.color;
            plot_and_check(q);
            q.z = p.z + 1000;
            q.color = rgb_t'(24'h102030);
            plot_and_check(q);
        end
        end_test("depth-tested plot");

        writes_before = write_count;
        p.x = 32'(400 * 256);
        p.y = 32'(10 * 256);
        p.z = 32'd5;
        p.color = rgb_t'(24'h00FF00);
        plot_and_check(p);
        p.x = 32'd0;
        plot_and_check(p);
        p.x = 32'(20 * 256);
        p.color = COLOR_KEY;
        plot_and_check(p);
        check_word(mem_data_t'(write_count), mem_data_t'(writes_before), '0);
        end_test("rejected pixels");

        writes_before = write_count;
        slave_write(MODE, 32'd7);
        slave_write(START, 32'd1);
        check_reg(START, 32'd1);
        run_job(32'd7);
        check_reg(START, 32'd0);
        check_reg(DONE, 32'd0);
        check_word(mem_data_t'(write_count), mem_data_t'(writes_before), '0);
        p.x = 32'(33 * 256);
        p.y = 32'(44 * 256);
        p.z = 32'd77;
        p.color = rgb_t'(24'h445566);
        plot_and_check(p);
        end_test("unsupported mode and restart");

        $display("tests: %0d ok, %0d failed; checks: %0d, errors: %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
